// ==== all.f ====
+incdir+logic
logic/ifu_pkg.sv
logic/l1i_cache.sv
logic/fetch_ctrl.sv
logic/l1i_cfg_regs.sv
logic/ifu_top.sv
tb/imem_model.sv
tb/tb_ifu_top.sv

// ==== logic/fetch_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ifu_config.svh"

module fetch_ctrl (
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   hit_i,
  input  wire ifu_pkg::inst_t   word_i,
  input  wire                   fetch_ready_i,
  input  wire                   redirect_valid_i,
  input  wire ifu_pkg::addr_t   redirect_pc_i,
  output ifu_pkg::addr_t        lookup_pc_o,
  output logic                  flush_o,
  output ifu_pkg::fetch_out_t   fetch_o
);
  import ifu_pkg::*;

  addr_t      pc_q;
  logic       stall_q;
  logic [6:0] opcode;
  logic       is_cf;
  logic       is_fence_i;
  logic       xfer;

  assign lookup_pc_o = pc_q;

  // Valid follows the cache directly, so a hit shows in the same cycle
  assign fetch_o.valid = hit_i && !stall_q;
  assign fetch_o.inst  = word_i;
  assign fetch_o.pc    = pc_q;

  assign xfer = fetch_o.valid && fetch_ready_i;

  assign opcode = word_i[6:0];

  always_comb begin
    case (opcode)
      `OP_JAL,
      `OP_JALR,
      `OP_BRANCH,
      `OP_SYSTEM: is_cf = 1'b1;
      default:    is_cf = 1'b0;
    endcase
  end

  assign is_fence_i = (word_i == `INST_FENCE_I);

  // Cache drops all lines on the next edge
  assign flush_o = xfer && is_fence_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q    <= `IFU_RESET_PC;
      stall_q <= 1'b0;
    end else begin
      if (stall_q) begin
        // Redirect only counts while waiting on control flow
        if (redirect_valid_i) begin
          pc_q    <= redirect_pc_i;
          stall_q <= 1'b0;
        end
      end else if (xfer) begin
        if (is_cf) begin
          stall_q <= 1'b1;
        end else begin
          pc_q <= pc_q + 32'd4;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/ifu_config.svh ====
`ifndef IFU_CONFIG_SVH
`define IFU_CONFIG_SVH

// Fetch start address
`define IFU_RESET_PC 32'h8000_0000

// L1I geometry, 4 sets of two-word lines
`define L1I_SETS       4
`define L1I_IDX_W      2
`define L1I_LINE_WORDS 2
`define L1I_OFF_W      1
`define L1I_TAG_W      27

// Opcodes that stall fetch until execute redirects
`define OP_JAL    7'b1101111
`define OP_JALR   7'b1100111
`define OP_BRANCH 7'b1100011
`define OP_SYSTEM 7'b1110011

`define INST_FENCE_I 32'h0000_100f

// Config register map
`define CFG_ADDR_CTRL    2'd0
`define CFG_ADDR_HITS    2'd1
`define CFG_ADDR_REFILLS 2'd2

`endif

// ==== logic/ifu_pkg.sv ====
`default_nettype none

`include "ifu_config.svh"

package ifu_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] inst_t;
  typedef logic [`L1I_TAG_W-1:0] tag_t;
  typedef logic [`L1I_IDX_W-1:0] idx_t;
  typedef logic [31:0] cnt_t;

  typedef enum logic [1:0] {
    IDLE,
    REQ_LO,
    REQ_HI
  } refill_state_e;

  // Read request, level held until rvalid
  typedef struct packed {
    addr_t araddr;
    logic  arvalid;
  } bus_req_t;

  typedef struct packed {
    inst_t rdata;
    logic  rvalid;
  } bus_rsp_t;

  // Toward decode
  typedef struct packed {
    inst_t inst;
    addr_t pc;
    logic  valid;
  } fetch_out_t;

endpackage

`default_nettype wire

// ==== logic/ifu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ifu_top (
  input  wire                    clk,
  input  wire                    rst,
  input  wire ifu_pkg::bus_rsp_t bus_rsp_i,
  input  wire                    fetch_ready_i,
  input  wire                    redirect_valid_i,
  input  wire ifu_pkg::addr_t    redirect_pc_i,
  input  wire                    cfg_we_i,
  input  wire [1:0]              cfg_addr_i,
  input  wire ifu_pkg::cnt_t     cfg_wdata_i,
  output ifu_pkg::bus_req_t      bus_req_o,
  output ifu_pkg::fetch_out_t    fetch_o,
  output ifu_pkg::cnt_t          cfg_rdata_o
);
  import ifu_pkg::*;

  addr_t lookup_pc;
  logic  flush;
  logic  hit;
  inst_t word;
  logic  cache_en;
  logic  hit_evt;
  logic  refill_evt;

  fetch_ctrl u_fetch_ctrl (
    .clk              (clk),
    .rst              (rst),
    .hit_i            (hit),
    .word_i           (word),
    .fetch_ready_i    (fetch_ready_i),
    .redirect_valid_i (redirect_valid_i),
    .redirect_pc_i    (redirect_pc_i),
    .lookup_pc_o      (lookup_pc),
    .flush_o          (flush),
    .fetch_o          (fetch_o)
  );

  l1i_cache u_l1i_cache (
    .clk          (clk),
    .rst          (rst),
    .lookup_pc_i  (lookup_pc),
    .flush_i      (flush),
    .cache_en_i   (cache_en),
    .bus_rsp_i    (bus_rsp_i),
    .hit_o        (hit),
    .word_o       (word),
    .bus_req_o    (bus_req_o),
    .hit_evt_o    (hit_evt),
    .refill_evt_o (refill_evt)
  );

  // Enable bit and event counters
  l1i_cfg_regs u_l1i_cfg_regs (
    .clk          (clk),
    .rst          (rst),
    .cfg_we_i     (cfg_we_i),
    .cfg_addr_i   (cfg_addr_i),
    .cfg_wdata_i  (cfg_wdata_i),
    .hit_evt_i    (hit_evt),
    .refill_evt_i (refill_evt),
    .cfg_rdata_o  (cfg_rdata_o),
    .cache_en_o   (cache_en)
  );

endmodule

`default_nettype wire

// ==== logic/l1i_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ifu_config.svh"

module l1i_cache (
  input  wire                   clk,
  input  wire                   rst,
  input  wire ifu_pkg::addr_t   lookup_pc_i,
  input  wire                   flush_i,
  input  wire                   cache_en_i,
  input  wire ifu_pkg::bus_rsp_t bus_rsp_i,
  output logic                  hit_o,
  output ifu_pkg::inst_t        word_o,
  output ifu_pkg::bus_req_t     bus_req_o,
  output logic                  hit_evt_o,
  output logic                  refill_evt_o
);
  import ifu_pkg::*;

  tag_t                  pc_tag;
  idx_t                  pc_idx;
  logic [`L1I_OFF_W-1:0] pc_off;

  tag_t                  tag_q  [`L1I_SETS];
  inst_t                 data_q [`L1I_SETS][`L1I_LINE_WORDS];
  logic [`L1I_SETS-1:0]  valid_q;

  refill_state_e         state_q;
  addr_t                 fill_pc_q;
  logic                  byp_mode_q;
  tag_t                  fill_tag;
  idx_t                  fill_idx;
  logic [`L1I_OFF_W-1:0] fill_off;

  // Uncached word, held until the PC moves on
  inst_t                 byp_word_q;
  addr_t                 byp_pc_q;
  logic                  byp_valid_q;

  // Last PC already counted or just refilled
  addr_t                 last_pc_q;
  logic                  last_valid_q;

  logic                  line_hit;
  logic                  byp_hit;
  logic                  miss_start;
  logic                  rsp_take;
  logic                  fill_done;

  assign pc_tag = lookup_pc_i[31 -: `L1I_TAG_W];
  assign pc_idx = lookup_pc_i[2 + `L1I_OFF_W +: `L1I_IDX_W];
  assign pc_off = lookup_pc_i[2 +: `L1I_OFF_W];

  assign fill_tag = fill_pc_q[31 -: `L1I_TAG_W];
  assign fill_idx = fill_pc_q[2 + `L1I_OFF_W +: `L1I_IDX_W];

  // Low word first, then high word
  always_comb begin
    fill_off    = '0;
    fill_off[0] = (state_q == REQ_HI);
  end

  assign line_hit = (state_q == IDLE) && valid_q[pc_idx] && (tag_q[pc_idx] == pc_tag);
  assign byp_hit  = (state_q == IDLE) && byp_valid_q && (byp_pc_q == lookup_pc_i);

  assign hit_o  = cache_en_i ? line_hit : byp_hit;
  assign word_o = cache_en_i ? data_q[pc_idx][pc_off] : byp_word_q;

  assign miss_start = (state_q == IDLE) && !hit_o;
  assign rsp_take   = (state_q != IDLE) && bus_rsp_i.rvalid;
  assign fill_done  = rsp_take && (byp_mode_q || (state_q == REQ_HI));

  assign bus_req_o.arvalid = (state_q != IDLE);
  assign bus_req_o.araddr  = byp_mode_q ? fill_pc_q
                                        : {fill_pc_q[31:2 + `L1I_OFF_W], fill_off, 2'b00};

  assign hit_evt_o    = cache_en_i && line_hit &&
                        !(last_valid_q && (last_pc_q == lookup_pc_i));
  assign refill_evt_o = miss_start;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q      <= IDLE;
      valid_q      <= '0;
      byp_mode_q   <= 1'b0;
      byp_valid_q  <= 1'b0;
      last_valid_q <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (miss_start) begin
            state_q    <= REQ_LO;
            byp_mode_q <= !cache_en_i;
          end
        end
        REQ_LO: begin
          if (bus_rsp_i.rvalid) begin
            state_q <= byp_mode_q ? IDLE : REQ_HI;
          end
        end
        REQ_HI: begin
          if (bus_rsp_i.rvalid) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase

      // Line valid only once both words are in
      if (flush_i) begin
        valid_q <= '0;
      end else if (fill_done && !byp_mode_q) begin
        valid_q[fill_idx] <= 1'b1;
      end

      if (flush_i) begin
        byp_valid_q <= 1'b0;
      end else if (fill_done && byp_mode_q) begin
        byp_valid_q <= 1'b1;
      end

      if (hit_evt_o || (fill_done && !byp_mode_q)) begin
        last_valid_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (miss_start) begin
      fill_pc_q <= lookup_pc_i;
    end
    if (rsp_take) begin
      if (byp_mode_q) begin
        byp_word_q <= bus_rsp_i.rdata;
        byp_pc_q   <= fill_pc_q;
      end else begin
        data_q[fill_idx][fill_off] <= bus_rsp_i.rdata;
      end
    end
    if (fill_done && !byp_mode_q) begin
      tag_q[fill_idx] <= fill_tag;
    end
    // A hit right after its own refill is not counted
    if (hit_evt_o) begin
      last_pc_q <= lookup_pc_i;
    end else if (fill_done && !byp_mode_q) begin
      last_pc_q <= fill_pc_q;
    end
  end

endmodule

`default_nettype wire

// ==== logic/l1i_cfg_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ifu_config.svh"

module l1i_cfg_regs (
  input  wire                  clk,
  input  wire                  rst,
  input  wire                  cfg_we_i,
  input  wire [1:0]            cfg_addr_i,
  input  wire ifu_pkg::cnt_t   cfg_wdata_i,
  input  wire                  hit_evt_i,
  input  wire                  refill_evt_i,
  output ifu_pkg::cnt_t        cfg_rdata_o,
  output logic                 cache_en_o
);
  import ifu_pkg::*;

  logic en_q;
  cnt_t hits_q;
  cnt_t refills_q;

  assign cache_en_o = en_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      en_q      <= 1'b1;
      hits_q    <= '0;
      refills_q <= '0;
    end else begin
      if (cfg_we_i && (cfg_addr_i == `CFG_ADDR_CTRL)) begin
        en_q <= cfg_wdata_i[0];
      end

      // Any write to a counter clears it
      if (cfg_we_i && (cfg_addr_i == `CFG_ADDR_HITS)) begin
        hits_q <= '0;
      end else if (hit_evt_i) begin
        hits_q <= hits_q + 32'd1;
      end

      if (cfg_we_i && (cfg_addr_i == `CFG_ADDR_REFILLS)) begin
        refills_q <= '0;
      end else if (refill_evt_i) begin
        refills_q <= refills_q + 32'd1;
      end
    end
  end

  always_comb begin
    case (cfg_addr_i)
      `CFG_ADDR_CTRL:    cfg_rdata_o = {31'd0, en_q};
      `CFG_ADDR_HITS:    cfg_rdata_o = hits_q;
      `CFG_ADDR_REFILLS: cfg_rdata_o = refills_q;
      default:           cfg_rdata_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the IFU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_ifu_top -Mdir obj_dir -o sim_ifu \
  -f all.f > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_ifu > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -q "^Simulation passed$" sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// ==== tb/imem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ifu_config.svh"

module imem_model (
  input  wire                    clk,
  input  wire                    rst,
  input  wire ifu_pkg::bus_req_t bus_req_i,
  output ifu_pkg::bus_rsp_t      bus_rsp_o,
  output int unsigned            req_count_o
);
  import ifu_pkg::*;

  localparam int WORDS   = 64;
  localparam int LATENCY = 2;

  inst_t mem [WORDS];
  addr_t addr_q;
  logic  busy_q;
  int    wait_q;

  // Word index relative to the reset vector
  function automatic logic [5:0] word_index(input addr_t addr);
    addr_t offs;
    offs = addr - `IFU_RESET_PC;
    return offs[7:2];
  endfunction

  task automatic write_word(input logic [5:0] index, input inst_t word);
    mem[index] = word;
  endtask

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q      <= 1'b0;
      wait_q      <= 0;
      req_count_o <= 0;
      bus_rsp_o   <= '0;
    end else begin
      bus_rsp_o.rvalid <= 1'b0;
      if (busy_q) begin
        if (wait_q == 1) begin
          bus_rsp_o.rvalid <= 1'b1;
          bus_rsp_o.rdata  <= mem[word_index(addr_q)];
          busy_q           <= 1'b0;
        end
        wait_q <= wait_q - 1;
      end else if (bus_req_i.arvalid && !bus_rsp_o.rvalid) begin
        // arvalid in the rvalid cycle still belongs to the old request
        busy_q      <= 1'b1;
        wait_q      <= LATENCY - 1;
        addr_q      <= bus_req_i.araddr;
        req_count_o <= req_count_o + 1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== tb/tb_ifu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ifu_config.svh"

module tb_ifu_top;
  import ifu_pkg::*;

  // The tests take a few hundred cycles
  localparam int    TIMEOUT_CYCLES = 4000;
  localparam int    PROG_WORDS     = 64;
  localparam int    FENCE_IDX      = 40;
  localparam inst_t NEW_WORD       = 32'h7ff0_0093;

  logic        clk;
  logic        rst;
  bus_req_t    bus_req;
  bus_rsp_t    bus_rsp;
  logic        fetch_ready;
  logic        redirect_valid;
  addr_t       redirect_pc;
  logic        cfg_we;
  logic [1:0]  cfg_addr;
  cnt_t        cfg_wdata;
  fetch_out_t  fetch;
  cnt_t        cfg_rdata;
  int unsigned req_count;

  inst_t       expect_mem [PROG_WORDS];
  cnt_t        hits_base;
  int          cycles = 0;
  int          errors = 0;
  int unsigned rnd;

  ifu_top uut (
    .clk              (clk),
    .rst              (rst),
    .bus_rsp_i        (bus_rsp),
    .fetch_ready_i    (fetch_ready),
    .redirect_valid_i (redirect_valid),
    .redirect_pc_i    (redirect_pc),
    .cfg_we_i         (cfg_we),
    .cfg_addr_i       (cfg_addr),
    .cfg_wdata_i      (cfg_wdata),
    .bus_req_o        (bus_req),
    .fetch_o          (fetch),
    .cfg_rdata_o      (cfg_rdata)
  );

  imem_model u_imem (
    .clk         (clk),
    .rst         (rst),
    .bus_req_i   (bus_req),
    .bus_rsp_o   (bus_rsp),
    .req_count_o (req_count)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout, tests still running after %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation failed");
      $fatal(1);
    end
  end

  function automatic addr_t word_addr(input int index);
    return `IFU_RESET_PC + 32'(index << 2);
  endfunction

  // addi x1, x1, imm with imm taken from the address
  function automatic inst_t addi_word(input addr_t addr);
    return {addr[31:20] ^ addr[13:2], 5'd1, 3'b000, 5'd1, 7'b0010011};
  endfunction

  task automatic load_word(input int index, input inst_t word);
    expect_mem[index] = word;
    u_imem.write_word(6'(index), word);
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  task automatic reset_dut();
    rst = 1'b1;
    repeat (2) @(negedge clk);
    rst = 1'b0;
  endtask

  task automatic wait_valid();
    while (!fetch.valid) @(negedge clk);
  endtask

  task automatic check_word(input int index);
    check_eq("fetch_o.pc", fetch.pc, word_addr(index));
    check_eq("fetch_o.inst", fetch.inst, expect_mem[index]);
  endtask

  task automatic read_reg(input logic [1:0] addr, output cnt_t value);
    cfg_addr = addr;
    @(negedge clk);
    value = cfg_rdata;
  endtask

  task automatic write_reg(input logic [1:0] addr, input cnt_t value);
    cfg_we    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = value;
    @(negedge clk);
    cfg_we = 1'b0;
  endtask

  task automatic redirect_to(input addr_t pc);
    redirect_valid = 1'b1;
    redirect_pc    = pc;
    @(negedge clk);
    redirect_valid = 1'b0;
  endtask

  // Transfers count words starting at first, optionally with ready stalls
  task automatic fetch_words(input int first, input int count, input bit backpressure);
    int hold;
    for (int n = 0; n < count; n++) begin
      fetch_ready = !backpressure;
      wait_valid();
      check_word(first + n);
      if (backpressure) begin
        hold = int'($urandom % 5);
        repeat (hold) begin
          @(negedge clk);
          check_eq("fetch_o.valid", 32'(fetch.valid), 32'd1);
          check_word(first + n);
        end
        fetch_ready = 1'b1;
      end
      @(negedge clk);
    end
    fetch_ready = 1'b0;
  endtask

  task automatic fetch_in_order();
    int unsigned base;
    base = req_count;
    fetch_words(0, 8, 1'b0);
    check_eq("req_count", req_count - base, 32'd8);
  endtask

  task automatic hold_under_backpressure();
    fetch_words(8, 8, 1'b1);
  endtask

  task automatic stall_and_redirect();
    load_word(7, {25'd0, `OP_JAL});
    reset_dut();
    fetch_words(0, 8, 1'b0);
    repeat (20) begin
      check_eq("fetch_o.valid", 32'(fetch.valid), 32'd0);
      @(negedge clk);
    end
    read_reg(`CFG_ADDR_HITS, hits_base);
    redirect_to(`IFU_RESET_PC);
    wait_valid();
    check_word(0);
  endtask

  task automatic refetch_hits();
    int unsigned base;
    cnt_t        value;
    base = req_count;
    fetch_words(0, 8, 1'b0);
    check_eq("req_count", req_count - base, 32'd0);
    read_reg(`CFG_ADDR_HITS, value);
    check_eq("hit counter delta", value - hits_base, 32'd8);
    read_reg(`CFG_ADDR_REFILLS, value);
    check_eq("refill counter", value, 32'd4);
  endtask

  task automatic flush_on_fence_i();
    int unsigned base;
    // Line 1 still holds the old word until the flush
    load_word(2, NEW_WORD);
    redirect_to(word_addr(FENCE_IDX));
    fetch_words(FENCE_IDX, 2, 1'b0);
    base = req_count;
    redirect_to(word_addr(2));
    wait_valid();
    check_word(2);
    check_eq("req_count", req_count - base, 32'd2);
  endtask

  task automatic fetch_uncached();
    int unsigned base;
    cnt_t        value;
    write_reg(`CFG_ADDR_CTRL, 32'd0);
    read_reg(`CFG_ADDR_CTRL, value);
    check_eq("cache enable", value, 32'd0);
    wait_valid();
    check_word(2);
    write_reg(`CFG_ADDR_HITS, 32'd0);
    write_reg(`CFG_ADDR_REFILLS, 32'd0);
    base = req_count;
    for (int n = 0; n < 4; n++) begin
      fetch_words(2 + n, 1, 1'b0);
      wait_valid();
      check_word(3 + n);
      check_eq("req_count", req_count - base, 32'(n + 1));
    end
    read_reg(`CFG_ADDR_REFILLS, value);
    check_eq("refill counter", value, 32'd4);
    read_reg(`CFG_ADDR_HITS, value);
    check_eq("hit counter", value, 32'd0);
  endtask

  initial begin
    rst            = 1'b1;
    fetch_ready    = 1'b0;
    redirect_valid = 1'b0;
    redirect_pc    = '0;
    cfg_we         = 1'b0;
    cfg_addr       = '0;
    cfg_wdata      = '0;
    rnd            = $urandom(32'h9e44_cd35);

    for (int i = 0; i < PROG_WORDS; i++) begin
      load_word(i, addi_word(word_addr(i)));
    end
    load_word(FENCE_IDX, `INST_FENCE_I);
    load_word(FENCE_IDX + 1, {25'd0, `OP_JAL});

    reset_dut();
    fetch_in_order();
    hold_under_backpressure();
    stall_and_redirect();
    refetch_hits();
    flush_on_fence_i();
    fetch_uncached();

    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
